// File: rtl/rpPkg.sv
package rpPkg;

   //////////////////////////////////////////////////
   // Register selects
   //////////////////////////////////////////////////

   // Mass-bus register numbers, octal as on the drive
   localparam logic [4:0] RP_SEL_CS1 = 5'o00;
   localparam logic [4:0] RP_SEL_DS  = 5'o01;
   localparam logic [4:0] RP_SEL_ER1 = 5'o02;
   localparam logic [4:0] RP_SEL_AS  = 5'o04;
   localparam logic [4:0] RP_SEL_DA  = 5'o05;
   localparam logic [4:0] RP_SEL_DC  = 5'o12;

   //////////////////////////////////////////////////
   // Function codes, CS1 bits 5:1
   //////////////////////////////////////////////////

   localparam logic [4:0] RP_FUN_NOP    = 5'o00;
   localparam logic [4:0] RP_FUN_SEEK   = 5'o02;
   localparam logic [4:0] RP_FUN_DRVCLR = 5'o04;
   localparam logic [4:0] RP_FUN_WRDATA = 5'o30;
   localparam logic [4:0] RP_FUN_RDDATA = 5'o34;

   // Geometry, highest legal value of each field
   localparam logic [4:0] RP_LAST_SECTOR = 5'd21;
   localparam logic [4:0] RP_LAST_TRACK  = 5'd18;
   localparam logic [9:0] RP_LAST_CYL    = 10'd814;

   // Busy length of one command in clocks
   localparam int unsigned RP_OP_CYCLES = 16;
   localparam int unsigned RP_OP_CNT_W  = $clog2(RP_OP_CYCLES + 1);

   //////////////////////////////////////////////////
   // ER1 bit layout
   //////////////////////////////////////////////////

   localparam int RP_ER1_DCK  = 15;
   localparam int RP_ER1_UNS  = 14;
   localparam int RP_ER1_IOP  = 13;
   localparam int RP_ER1_DTE  = 12;
   localparam int RP_ER1_WLE  = 11;
   localparam int RP_ER1_IAE  = 10;
   localparam int RP_ER1_AOE  = 9;
   localparam int RP_ER1_HCRC = 8;
   localparam int RP_ER1_HCE  = 7;
   localparam int RP_ER1_ECH  = 6;
   localparam int RP_ER1_WCF  = 5;
   localparam int RP_ER1_FER  = 4;
   localparam int RP_ER1_PAR  = 3;
   localparam int RP_ER1_RMR  = 2;
   localparam int RP_ER1_ILR  = 1;
   localparam int RP_ER1_ILF  = 0;

   // Host write word, seen as a CS1 command or as a DA address
   typedef union packed {
      struct packed {
         logic [9:0] rsvd;
         logic [4:0] fun;
         logic       go;
      } cs1;
      struct packed {
         logic [2:0] rsvdHi;
         logic [4:0] track;
         logic [2:0] rsvdLo;
         logic [4:0] sector;
      } da;
   } rpWord;

endpackage

// File: rtl/rpRegDecode.sv
`timescale 1ns/1ps

module rpRegDecode (
   input  logic         clk,
   input  logic         rst,
   input  logic         regWrite,
   input  logic [4:0]   regSel,
   input  logic [35:0]  dataIn,
   input  logic         writeLock,
   input  logic         dry,
   input  logic [15:0]  ds,
   input  logic [15:0]  er1,
   input  logic [15:0]  da,
   input  logic [15:0]  dc,
   output logic         goCmd,
   output logic [4:0]   func,
   output logic         er1Write,
   output logic         daWrite,
   output logic         dcWrite,
   output logic         drvClr,
   output logic         setRmr,
   output logic         setIlf,
   output logic         setPar,
   output logic         setWle,
   output rpPkg::rpWord word,
   output logic [15:0]  rdData,
   output logic         atn
);
   import rpPkg::*;

   logic        parOk;
   logic        wrOk;
   logic        busyTarget;
   logic        accept;
   logic        cs1Write;
   logic        goWrite;
   logic        legalFun;
   logic        asClear;
   logic [4:0]  newFun;
   logic [4:0]  funReg;
   logic        ata;
   logic        dryQ;
   logic        dryRise;
   logic        errPulse;
   logic [15:0] er1Q;

   //////////////////////////////////////////////////
   // Write qualification
   //////////////////////////////////////////////////

   // Odd parity across data and parity bit
   assign parOk  = ^dataIn[16:0];
   assign word   = dataIn[15:0];
   assign wrOk   = regWrite & parOk;
   // Bad parity drops the write entirely
   assign setPar = regWrite & ~parOk;

   // Registers locked while a command runs
   assign busyTarget = (regSel == RP_SEL_CS1) | (regSel == RP_SEL_DA) |
                       (regSel == RP_SEL_DC);
   assign setRmr     = wrOk & busyTarget & ~dry;
   assign accept     = wrOk & (dry | ~busyTarget);

   assign cs1Write = accept & (regSel == RP_SEL_CS1);
   assign daWrite  = accept & (regSel == RP_SEL_DA);
   assign dcWrite  = accept & (regSel == RP_SEL_DC);
   // ER1 does its own busy gating
   assign er1Write = wrOk & (regSel == RP_SEL_ER1);
   assign asClear  = wrOk & (regSel == RP_SEL_AS) & dataIn[0];

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   assign newFun  = word.cs1.fun;
   assign goWrite = cs1Write & word.cs1.go;

   always_comb
   begin
      case (newFun)
         RP_FUN_NOP, RP_FUN_SEEK, RP_FUN_DRVCLR,
         RP_FUN_WRDATA, RP_FUN_RDDATA: legalFun = 1'b1;
         default:                      legalFun = 1'b0;
      endcase
   end

   assign setIlf = goWrite & ~legalFun;
   assign drvClr = goWrite & (newFun == RP_FUN_DRVCLR);
   assign setWle = goWrite & (newFun == RP_FUN_WRDATA) & writeLock;
   // NOP never makes the drive busy
   assign goCmd  = goWrite & legalFun & (newFun != RP_FUN_NOP);

   // Bypass so the new code is seen at the GO edge
   assign func = cs1Write ? newFun : funReg;

   // Attention on command end or any new error bit
   assign dryRise  = dry & ~dryQ;
   assign errPulse = setRmr | setIlf | setPar | setWle | (|(er1 & ~er1Q));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         funReg <= '0;
         ata    <= 1'b0;
         dryQ   <= 1'b1;
         er1Q   <= '0;
      end
      else
      begin
         dryQ <= dry;
         er1Q <= er1;
         if (cs1Write)
            funReg <= newFun;
         // Set wins over a clear in the same cycle
         if (errPulse | dryRise)
            ata <= 1'b1;
         else if (asClear)
            ata <= 1'b0;
      end
   end

   assign atn = ata;

   // Read mux, GO reads back as busy
   always_comb
   begin
      case (regSel)
         RP_SEL_CS1: rdData = {10'd0, funReg, ~dry};
         RP_SEL_DS:  rdData = {ata, ds[14:0]};
         RP_SEL_ER1: rdData = er1;
         RP_SEL_AS:  rdData = {15'd0, ata};
         RP_SEL_DA:  rdData = da;
         RP_SEL_DC:  rdData = dc;
         default:    rdData = 16'd0;
      endcase
   end

endmodule

// File: rtl/rpDiskAddr.sv
`timescale 1ns/1ps

module rpDiskAddr (
   input  logic         clk,
   input  logic         rst,
   input  logic         clr,
   input  logic         drvClr,
   input  logic         daWrite,
   input  logic         dcWrite,
   input  rpPkg::rpWord word,
   input  logic         goCmd,
   input  logic [4:0]   func,
   input  logic         opDone,
   output logic         setIae,
   output logic         setAoe,
   output logic [15:0]  da,
   output logic [15:0]  dc
);
   import rpPkg::*;

   logic [4:0] sector;
   logic [4:0] track;
   logic [9:0] cyl;
   logic       dataCmd;
   logic       addrBad;
   logic       lastAddr;
   // Transfer in flight with a good address
   logic       xfer;

   assign dataCmd  = (func == RP_FUN_WRDATA) | (func == RP_FUN_RDDATA);
   assign addrBad  = (sector > RP_LAST_SECTOR) | (track > RP_LAST_TRACK) |
                     (cyl > RP_LAST_CYL);
   assign lastAddr = (sector == RP_LAST_SECTOR) & (track == RP_LAST_TRACK) &
                     (cyl == RP_LAST_CYL);

   assign setIae = goCmd & dataCmd & addrBad;
   assign setAoe = opDone & xfer & lastAddr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sector <= '0;
         track  <= '0;
         cyl    <= '0;
         xfer   <= 1'b0;
      end
      else if (clr | drvClr)
      begin
         sector <= '0;
         track  <= '0;
         cyl    <= '0;
         xfer   <= 1'b0;
      end
      else
      begin
         //////////////////////////////////////////////////
         // End of transfer, step sector then track then cylinder
         //////////////////////////////////////////////////
         if (opDone & xfer)
         begin
            xfer <= 1'b0;
            if (sector != RP_LAST_SECTOR)
               sector <= sector + 5'd1;
            else
            begin
               sector <= '0;
               if (track != RP_LAST_TRACK)
                  track <= track + 5'd1;
               else
               begin
                  track <= '0;
                  // Past the last cylinder the address folds to zero
                  cyl <= (cyl == RP_LAST_CYL) ? 10'd0 : cyl + 10'd1;
               end
            end
         end
         if (goCmd)
            xfer <= dataCmd & ~addrBad;
         // Host writes take priority
         if (daWrite)
         begin
            sector <= word.da.sector;
            track  <= word.da.track;
         end
         if (dcWrite)
            cyl <= word[9:0];
      end
   end

   assign da = {3'd0, track, 3'd0, sector};
   assign dc = {6'd0, cyl};

endmodule

// File: rtl/rpErr1.sv
`timescale 1ns/1ps

module rpErr1 (
   input  logic         clk,
   input  logic         rst,
   input  logic         clr,
   input  logic         drvClr,
   input  logic         er1Write,
   input  logic         dry,
   input  rpPkg::rpWord word,
   input  logic         setWle,
   input  logic         setIae,
   input  logic         setAoe,
   input  logic         setPar,
   input  logic         setRmr,
   input  logic         setIlf,
   output logic [15:0]  er1
);
   import rpPkg::*;

   logic [15:0] setVec;
   logic        hostLoad;
   logic        clearAll;

   //////////////////////////////////////////////////
   // Hardware set sources
   //////////////////////////////////////////////////

   // Only six bits have a hardware source
   always_comb
   begin
      setVec              = '0;
      setVec[RP_ER1_WLE]  = setWle;
      setVec[RP_ER1_IAE]  = setIae;
      setVec[RP_ER1_AOE]  = setAoe;
      setVec[RP_ER1_PAR]  = setPar;
      setVec[RP_ER1_RMR]  = setRmr;
      setVec[RP_ER1_ILF]  = setIlf;
   end

   // DCK UNS IOP DTE HCRC HCE ECH WCF FER ILR
   // are host written or cleared only

   // Host load only when the drive is idle
   assign hostLoad = er1Write & dry;

   // Bus clear and drive clear
   assign clearAll = clr | drvClr;

   //////////////////////////////////////////////////
   // Error flip-flops
   //////////////////////////////////////////////////

   // Per bit priority
   //   clear
   //   hardware set
   //   host load
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (clearAll)
         er1 <= '0;
      else
      begin
         for (int i = 0; i < 16; i++)
         begin
            if (setVec[i])
               er1[i] <= 1'b1;
            else if (hostLoad)
               er1[i] <= word[i];
         end
      end
   end

endmodule

// File: rtl/rpStatus.sv
`timescale 1ns/1ps

module rpStatus (
   input  logic        clk,
   input  logic        rst,
   input  logic        goCmd,
   input  logic [15:0] er1,
   output logic        dry,
   output logic        opDone,
   output logic [15:0] ds
);
   import rpPkg::*;

   // Clocks left in the current command
   logic [RP_OP_CNT_W-1:0] opCnt;
   logic                   err;

   //////////////////////////////////////////////////
   // Busy timer
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         opCnt  <= '0;
         opDone <= 1'b0;
      end
      else
      begin
         // Last count step, done lines up with DRY rising
         opDone <= (opCnt == RP_OP_CNT_W'(1));
         if (goCmd)
            opCnt <= RP_OP_CNT_W'(RP_OP_CYCLES);
         else if (opCnt != '0)
            opCnt <= opCnt - 1'b1;
      end
   end

   // Ready whenever the timer is idle
   assign dry = (opCnt == '0);

   // Any ER1 bit is a drive error
   assign err = |er1;

   //////////////////////////////////////////////////
   // Drive status word
   //////////////////////////////////////////////////

   // Bit 15 ATA is merged in on read
   // Bit 14 ERR
   // Bit 8  drive present, always one here
   // Bit 7  DRY
   assign ds = {1'b0, err, 5'd0, 1'b1, dry, 7'd0};

endmodule

// File: rtl/rpDrive.sv
`timescale 1ns/1ps

module rpDrive (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        regWrite,
   input  logic [4:0]  regSel,
   input  logic [35:0] dataIn,
   input  logic        writeLock,
   output logic [15:0] rdData,
   output logic        dry,
   output logic        atn
);
   import rpPkg::*;

   // Decode outputs
   logic        goCmd;
   logic [4:0]  func;
   logic        er1Write;
   logic        daWrite;
   logic        dcWrite;
   logic        drvClr;
   logic        setRmr;
   logic        setIlf;
   logic        setPar;
   logic        setWle;
   rpWord       word;

   // Address and status
   logic        setIae;
   logic        setAoe;
   logic [15:0] da;
   logic [15:0] dc;
   logic        opDone;
   logic [15:0] ds;
   logic [15:0] er1;

   //////////////////////////////////////////////////
   // Host port and command decode
   //////////////////////////////////////////////////

   rpRegDecode u_rpRegDecode (
      .clk(clk), .rst(rst), .regWrite(regWrite), .regSel(regSel),
      .dataIn(dataIn), .writeLock(writeLock), .dry(dry), .ds(ds),
      .er1(er1), .da(da), .dc(dc), .goCmd(goCmd), .func(func),
      .er1Write(er1Write), .daWrite(daWrite), .dcWrite(dcWrite),
      .drvClr(drvClr), .setRmr(setRmr), .setIlf(setIlf), .setPar(setPar),
      .setWle(setWle), .word(word), .rdData(rdData), .atn(atn)
   );

   // Track, sector and cylinder
   rpDiskAddr u_rpDiskAddr (
      .clk(clk), .rst(rst), .clr(clr), .drvClr(drvClr), .daWrite(daWrite),
      .dcWrite(dcWrite), .word(word), .goCmd(goCmd), .func(func),
      .opDone(opDone), .setIae(setIae), .setAoe(setAoe), .da(da), .dc(dc)
   );

   rpErr1 u_rpErr1 (
      .clk(clk), .rst(rst), .clr(clr), .drvClr(drvClr), .er1Write(er1Write),
      .dry(dry), .word(word), .setWle(setWle), .setIae(setIae),
      .setAoe(setAoe), .setPar(setPar), .setRmr(setRmr), .setIlf(setIlf),
      .er1(er1)
   );

   // Busy timer and DS
   rpStatus u_rpStatus (
      .clk(clk), .rst(rst), .goCmd(goCmd), .er1(er1),
      .dry(dry), .opDone(opDone), .ds(ds)
   );

endmodule

// File: tb/rpDriveTb.sv
`timescale 1ns/1ps

module rpDriveTb;
   import rpPkg::*;

   logic        clk;
   logic        rst;
   logic        clr;
   logic        regWrite;
   logic [4:0]  regSel;
   logic [35:0] dataIn;
   logic        writeLock;
   logic [15:0] rdData;
   logic        dry;
   logic        atn;

   // One text line of the stimulus file and its fields
   logic [8*160-1:0] line;
   logic [8*24-1:0]  testName;
   logic [7:0]       op;
   logic [4:0]       sel;
   logic [16:0]      data;
   logic             wl;
   logic [15:0]      expVal;
   int               fd;
   int               rc;
   int               passCount;
   int               failCount;
   logic             stopRun;

   rpDrive u_rpDrive (
      .clk(clk), .rst(rst), .clr(clr), .regWrite(regWrite), .regSel(regSel),
      .dataIn(dataIn), .writeLock(writeLock), .rdData(rdData), .dry(dry), .atn(atn)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic checkWord(input logic [8*24-1:0] name, input logic [15:0] expected,
                            input logic [15:0] actual);
      if (actual === expected)
      begin
         passCount++;
         $display("ok    %0s read %h", name, actual);
      end
      else
      begin
         failCount++;
         $display("error %0s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic checkBit(input logic [8*24-1:0] name, input logic expected,
                           input logic actual);
      if (actual === expected)
      begin
         passCount++;
         $display("ok    %0s bit %b", name, actual);
      end
      else
      begin
         failCount++;
         $display("error %0s expected %b actual %b", name, expected, actual);
      end
   endtask

   //////////////////////////////////////////////////
   // Bus operations, each starts and ends on a falling edge
   //////////////////////////////////////////////////

   task automatic writeReg(input logic [4:0] s, input logic [16:0] d, input logic lock);
      regSel    = s;
      dataIn    = {19'd0, d};
      writeLock = lock;
      regWrite  = 1'b1;
      @(negedge clk);
      regWrite  = 1'b0;
      writeLock = 1'b0;
   endtask

   // Sample a quarter period after the falling edge
   task automatic readReg(input logic [8*24-1:0] name, input logic [4:0] s,
                          input logic [15:0] expected);
      regSel = s;
      #25;
      checkWord(name, expected, rdData);
      @(negedge clk);
   endtask

   task automatic sampleAtn(input logic [8*24-1:0] name, input logic expected);
      #25;
      checkBit(name, expected, atn);
      @(negedge clk);
   endtask

   // Poll dry, bounded well past one command length
   task automatic waitDry(input logic [8*24-1:0] name, input logic expected,
                          output logic timedOut);
      int n;
      n = 0;
      timedOut = 1'b0;
      // A GO command leaves the drive busy
      checkBit(name, 1'b0, dry);
      while (dry !== 1'b1 && n < 4 * RP_OP_CYCLES)
      begin
         @(negedge clk);
         n++;
      end
      if (dry !== 1'b1)
      begin
         timedOut = 1'b1;
         failCount++;
         $display("%0s: dry never returned within %0d clocks", name, n);
      end
      else
      begin
         // Command end raises attention one clock after DRY
         @(negedge clk);
         #25;
         checkBit(name, expected, atn);
         @(negedge clk);
      end
   endtask

   task automatic pulseClr();
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
   endtask

   // Dispatch one record of the stimulus file
   task automatic runRecord();
      logic timedOut;
      timedOut = 1'b0;
      case (op)
         "W":
         begin
            writeReg(sel, data, wl);
            $display("done  %0s write %h", testName, data);
         end
         "R":     readReg(testName, sel, expVal);
         "A":     sampleAtn(testName, expVal[0]);
         "D":     waitDry(testName, expVal[0], timedOut);
         "C":
         begin
            pulseClr();
            $display("done  %0s bus clear", testName);
         end
         default:
         begin
            failCount++;
            $display("%0s: unknown operation in stimulus file", testName);
         end
      endcase
      if (timedOut)
         stopRun = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst       = 1'b1;
      clr       = 1'b0;
      regWrite  = 1'b0;
      regSel    = '0;
      dataIn    = '0;
      writeLock = 1'b0;
      passCount = 0;
      failCount = 0;
      stopRun   = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      fd = $fopen("tb/rpInput.txt", "r");
      if (fd == 0)
      begin
         failCount++;
         stopRun = 1'b1;
         $display("could not open the stimulus file tb/rpInput.txt");
      end
      while (!stopRun && !$feof(fd))
      begin
         rc = $fgets(line, fd);
         // Comment and blank lines do not give six fields
         if (rc > 0)
         begin
            rc = $sscanf(line, "%s %s %h %h %h %h", testName, op, sel, data, wl, expVal);
            if (rc == 6)
               runRecord();
         end
      end
      if (fd != 0)
         $fclose(fd);

      $display("checks passed %0d failed %0d", passCount, failCount);
      if (failCount == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: tb/rpInput.txt
# name op sel data wl expect, all hex, data bit 16 is the odd parity bit
# ops W write, R read and compare, A check atn, D wait for dry, C pulse clr
rstEr1    R 02 00000 0 0000
rstDa     R 05 00000 0 0000
rstDc     R 0a 00000 0 0000
rstDs     R 01 00000 0 0180
rstAtn    A 00 00000 0 0
er1Pat    W 02 0c100 0 0000
er1Rd     R 02 00000 0 c100
er1Zero   W 02 10000 0 0000
asClr1    W 04 00001 0 0000
atnClr    A 00 00000 0 0
ilfCmd    W 00 10003 0 0000
ilfEr1    R 02 00000 0 0001
ilfAtn    A 00 00000 0 1
asClr2    W 04 00001 0 0000
seekCmd   W 00 10005 0 0000
rmrDa     W 05 00103 0 0000
rmrAtn    A 00 00000 0 1
seekDone  D 00 00000 0 1
rmrDaRd   R 05 00000 0 0000
rmrEr1    R 02 00000 0 0005
asClr3    W 04 00001 0 0000
wleCmd    W 00 00031 1 0000
wleAtn    A 00 00000 0 1
wleDone   D 00 00000 0 1
wleEr1    R 02 00000 0 0805
wleDa     R 05 00000 0 0001
parDc     W 0a 00005 0 0000
parDcRd   R 0a 00000 0 0000
parEr1    R 02 00000 0 080d
iaeDa     W 05 00016 0 0000
iaeCmd    W 00 10039 0 0000
iaeDone   D 00 00000 0 1
iaeEr1    R 02 00000 0 0c0d
aoeDa     W 05 01215 0 0000
aoeDc     W 0a 1032e 0 0000
aoeCmd    W 00 10039 0 0000
aoeDone   D 00 00000 0 1
aoeEr1    R 02 00000 0 0e0d
aoeDaRd   R 05 00000 0 0000
aoeDcRd   R 0a 00000 0 0000
normDa    W 05 10204 0 0000
normCmd   W 00 10039 0 0000
normDone  D 00 00000 0 1
normDaRd  R 05 00000 0 0205
asClr4    W 04 00001 0 0000
dsErr     R 01 00000 0 4180
dclrCmd   W 00 10009 0 0000
dclrDone  D 00 00000 0 1
dclrEr1   R 02 00000 0 0000
dclrDa    R 05 00000 0 0000
asClr5    W 04 00001 0 0000
dsClean   R 01 00000 0 0180
atnOff    A 00 00000 0 0
clrPat    W 02 15a5a 0 0000
clrPatRd  R 02 00000 0 5a5a
clrPulse  C 00 00000 0 0000
clrEr1    R 02 00000 0 0000
asClr6    W 04 00001 0 0000
atnEnd    A 00 00000 0 0

// File: flist.f
rtl/rpPkg.sv
rtl/rpRegDecode.sv
rtl/rpDiskAddr.sv
rtl/rpErr1.sv
rtl/rpStatus.sv
rtl/rpDrive.sv
tb/rpDriveTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the drive register testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module rpDriveTb -o rpDriveSim

./obj_dir/rpDriveSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
